// ==== build.f ====
uncorePkg.sv
busControl.sv
subwordWrite.sv
dtim.sv
clint.sv
gpio.sv
uncore.sv
tbUncore.sv

// ==== Bender.yml ====
package:
  name: uncore

sources:
  - files:
      - uncorePkg.sv
      - busControl.sv
      - subwordWrite.sv
      - dtim.sv
      - clint.sv
      - gpio.sv
      - uncore.sv
  - target: test
    files:
      - tbUncore.sv

// ==== tbUncore.sv ====
// testbench for the uncore slice
// AHB-Lite master tasks, dtim reference model
// concurrent protocol checks, cycle timeout and closing report
`timescale 1ns/1ps
`default_nettype none

module tbUncore import uncorePkg::*; ();

  logic            HCLK = 1'b0;
  logic            reset;
  logic [XLEN-1:0] hAddr, hWData, hRData;
  logic            hWrite, hReady, hResp;
  hsizeT           hSize;
  htransT          hTrans;
  logic            TimerIntM, SwIntM, GPIOIntr;
  logic [XLEN-1:0] GPIOPinsIn, GPIOPinsOut, GPIOPinsEn;

  // dtim mirror and the words written so far
  logic [XLEN-1:0] model [TIM_WORDS];
  int              written [$];
  string           testName = "reset";
  logic            rawWindow = 1'b0;
  int              valueErrors = 0;
  int              ruleErrors = 0;
  int              cycles = 0;
  // limit well above the roughly 2500 cycles of stimulus
  int              cycleLimit = 6000;

  uncore dut0 (
    .HCLK, .reset,
    .hAddr, .hWData, .hWrite, .hSize, .hTrans,
    .hRData, .hReady, .hResp,
    .TimerIntM, .SwIntM, .GPIOIntr,
    .GPIOPinsIn, .GPIOPinsOut, .GPIOPinsEn);

  always #10 HCLK = ~HCLK;

  always @(posedge HCLK) begin
    cycles++;
    if (cycles >= cycleLimit) begin
      $display("timeout: run did not finish within %0d cycles", cycleLimit);
      $display("** FAIL **");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // protocol checks
  //////////////////////////////////////////////////////////////////////

  // outputs idle right after reset
  assert property (@(posedge HCLK) $fell(reset) |->
      (hReady && !hResp && !TimerIntM && !SwIntM && !GPIOIntr && GPIOPinsEn == '0))
    else begin
      ruleErrors++;
      $display("outputs were not in their reset state when reset was released");
    end

  // unmapped access completes at once with zero data
  assert property (@(posedge HCLK) disable iff (reset) hResp |-> (hReady && hRData == '0))
    else begin
      ruleErrors++;
      $display("Error %s: error response expected ready %h data %h actual ready %h data %h",
               testName, 1'b1, 32'h0, $sampled(hReady), $sampled(hRData));
    end

  // only a dtim read after write may stall
  assert property (@(posedge HCLK) disable iff (reset) !hReady |-> rawWindow)
    else begin
      ruleErrors++;
      $display("hReady went low outside a dtim read after write in %s", testName);
    end

  assert property (@(posedge HCLK) disable iff (reset) !hReady |=> hReady)
    else begin
      ruleErrors++;
      $display("hReady stayed low for more than one cycle in %s", testName);
    end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
      else begin
        valueErrors++;
        $display("Error %s: expected %h actual %h", name, exp, act);
      end
  endtask

  function automatic logic [31:0] timAddr(input int idx);
    return TIM_BASE + (idx << 2);
  endfunction

  // byte enable rule applied to the mirror
  function automatic void updateModel(input int idx, input int off, input hsizeT size,
                                      input logic [31:0] data);
    if (size == BYTE) begin
      model[idx][off*8 +: 8] = data[7:0];
    end else if (size == HALF) begin
      model[idx][off*8 +: 16] = data[15:0];
    end else begin
      model[idx] = data;
    end
  endfunction

  // single NONSEQ transfer with address phase and data phase
  task automatic doTransfer(input logic [31:0] addr, input logic [31:0] wData,
                            input logic write, input hsizeT size, input logic expResp,
                            output logic [31:0] rData);
    @(posedge HCLK);
    hAddr  <= addr;
    hTrans <= NONSEQ;
    hWrite <= write;
    hSize  <= size;
    @(negedge HCLK);
    while (!hReady) @(negedge HCLK);
    @(posedge HCLK);
    hTrans <= IDLE;
    hWData <= wData;
    // data phase ends on the first edge with hReady high
    @(negedge HCLK);
    while (!hReady) @(negedge HCLK);
    rData = hRData;
    checkValue({testName, " hResp"}, expResp, hResp);
    @(posedge HCLK);
  endtask

  task automatic ahbWrite(input logic [31:0] addr, input logic [31:0] data, input hsizeT size);
    logic [31:0] unused;
    doTransfer(addr, data, 1'b1, size, 1'b0, unused);
  endtask

  task automatic ahbRead(input logic [31:0] addr, output logic [31:0] data);
    doTransfer(addr, 32'h0, 1'b0, WORD, 1'b0, data);
  endtask

  // word write with the read address phase in its data phase
  task automatic writeThenRead(input logic [31:0] wAddr, input logic [31:0] wData,
                               input logic [31:0] rAddr, output logic [31:0] rData,
                               output int stalls);
    stalls = 0;
    @(posedge HCLK);
    hAddr  <= wAddr;
    hTrans <= NONSEQ;
    hWrite <= 1'b1;
    hSize  <= WORD;
    @(negedge HCLK);
    while (!hReady) @(negedge HCLK);
    @(posedge HCLK);
    hAddr  <= rAddr;
    hWrite <= 1'b0;
    hWData <= wData;
    @(negedge HCLK);
    while (!hReady) @(negedge HCLK);
    // write data phase response
    checkValue({testName, " hResp"}, 1'b0, hResp);
    @(posedge HCLK);
    hTrans <= IDLE;
    @(negedge HCLK);
    while (!hReady) begin
      stalls++;
      @(negedge HCLK);
    end
    rData = hRData;
    checkValue({testName, " hResp"}, 1'b0, hResp);
    @(posedge HCLK);
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    int          idx, other, off, stalls, waited;
    logic [31:0] data, rd, t1, t2, pinBit;
    hsizeT       size;
    void'($urandom(32'he2b7ad4a));
    reset      <= 1'b1;
    hAddr      <= '0;
    hWData     <= '0;
    hWrite     <= 1'b0;
    hSize      <= WORD;
    hTrans     <= IDLE;
    GPIOPinsIn <= '0;
    repeat (2) @(posedge HCLK);
    reset <= 1'b0;

    testName = "dtim word round trip";
    for (int i = 0; i < 64; i++) begin
      idx  = $urandom % TIM_WORDS;
      data = $urandom;
      ahbWrite(timAddr(idx), data, WORD);
      model[idx] = data;
      written.push_back(idx);
    end
    foreach (written[i]) begin
      ahbRead(timAddr(written[i]), rd);
      checkValue(testName, model[written[i]], rd);
    end

    // sub-word stores land on known words only
    testName = "subword merge";
    for (int i = 0; i < 200; i++) begin
      idx  = written[$urandom % written.size()];
      size = ($urandom % 2) ? HALF : BYTE;
      off  = (size == HALF) ? 2 * ($urandom % 2) : $urandom % 4;
      data = $urandom;
      ahbWrite(timAddr(idx) + off, data, size);
      updateModel(idx, off, size, data);
      ahbRead(timAddr(idx), rd);
      checkValue(testName, model[idx], rd);
    end

    testName = "read after write";
    for (int i = 0; i < 16; i++) begin
      idx   = $urandom % TIM_WORDS;
      other = idx ^ 1;
      data  = $urandom;
      ahbWrite(timAddr(other), data, WORD);
      model[other] = data;
      data       = $urandom;
      model[idx] = data;
      rawWindow  = 1'b1;
      writeThenRead(timAddr(idx), data, timAddr(idx), rd, stalls);
      rawWindow  = 1'b0;
      checkValue(testName, model[idx], rd);
      checkValue({testName, " wait states"}, 1, stalls);
      // neighbouring word read must not stall
      data       = $urandom;
      model[idx] = data;
      writeThenRead(timAddr(idx), data, timAddr(other), rd, stalls);
      checkValue({testName, " other word"}, model[other], rd);
      checkValue({testName, " other word wait states"}, 0, stalls);
    end

    testName = "unmapped access";
    doTransfer(32'h4000_0000, 32'h0, 1'b0, WORD, 1'b1, rd);
    checkValue(testName, 32'h0, rd);
    doTransfer(32'h0000_1000, $urandom, 1'b1, WORD, 1'b1, rd);
    doTransfer(TIM_BASE + 32'h400, 32'h0, 1'b0, WORD, 1'b1, rd);
    checkValue(testName, 32'h0, rd);

    testName = "clint mtime";
    ahbRead(CLINT_BASE + MTIME_OFF, t1);
    ahbRead(CLINT_BASE + MTIME_OFF, t2);
    assert (t2 >= t1)
      else begin
        valueErrors++;
        $display("Error %s: expected at least %h actual %h", testName, t1, t2);
      end

    // high compare word first so the timer stays quiet
    testName = "clint timer";
    ahbWrite(CLINT_BASE + MTIMECMP_OFF + 4, 32'h0, WORD);
    ahbRead(CLINT_BASE + MTIME_OFF, t1);
    ahbWrite(CLINT_BASE + MTIMECMP_OFF, t1 + 100, WORD);
    @(negedge HCLK);
    checkValue(testName, 1'b0, TimerIntM);
    waited = 0;
    while (!TimerIntM && waited < 300) begin
      @(negedge HCLK);
      waited++;
    end
    checkValue({testName, " rise"}, 1'b1, TimerIntM);

    testName = "clint msip";
    ahbWrite(CLINT_BASE + MSIP_OFF, 32'h1, WORD);
    @(negedge HCLK);
    checkValue(testName, 1'b1, SwIntM);
    ahbWrite(CLINT_BASE + MSIP_OFF, 32'h0, WORD);
    @(negedge HCLK);
    checkValue(testName, 1'b0, SwIntM);

    testName = "gpio outputs";
    data = $urandom;
    ahbWrite(GPIO_BASE + OUTPUT_VAL_OFF, data, WORD);
    @(negedge HCLK);
    checkValue(testName, data, GPIOPinsOut);
    data = $urandom;
    ahbWrite(GPIO_BASE + OUTPUT_EN_OFF, data, WORD);
    @(negedge HCLK);
    checkValue({testName, " enable"}, data, GPIOPinsEn);

    testName = "gpio rise interrupt";
    pinBit = 32'h1 << ($urandom % 32);
    ahbWrite(GPIO_BASE + INPUT_EN_OFF, pinBit, WORD);
    ahbWrite(GPIO_BASE + RISE_IE_OFF, pinBit, WORD);
    @(negedge HCLK);
    checkValue(testName, 1'b0, GPIOIntr);
    @(posedge HCLK);
    GPIOPinsIn <= pinBit;
    // two synchroniser flops and the edge detector
    repeat (4) @(posedge HCLK);
    ahbRead(GPIO_BASE + INPUT_VAL_OFF, rd);
    checkValue({testName, " input_val"}, pinBit, rd);
    @(negedge HCLK);
    checkValue(testName, 1'b1, GPIOIntr);
    ahbWrite(GPIO_BASE + RISE_IP_OFF, pinBit, WORD);
    @(negedge HCLK);
    checkValue({testName, " clear"}, 1'b0, GPIOIntr);

    repeat (2) @(posedge HCLK);
    $display("errors: %0d value mismatches, %0d rule violations", valueErrors, ruleErrors);
    if (valueErrors == 0 && ruleErrors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== uncore.sv ====
// uncore top level
// AHB-Lite slave with bus control and sub-word write path
// dtim, clint and gpio peripherals with their interrupt pins
`timescale 1ns/1ps
`default_nettype none

module uncore import uncorePkg::*; (
  input  logic            HCLK,
  input  logic            reset,
  // AHB-Lite slave side
  input  logic [XLEN-1:0] hAddr,
  input  logic [XLEN-1:0] hWData,
  input  logic            hWrite,
  input  hsizeT           hSize,
  input  htransT          hTrans,
  output logic [XLEN-1:0] hRData,
  output logic            hReady,
  output logic            hResp,
  // interrupts straight out
  output logic            TimerIntM,
  output logic            SwIntM,
  output logic            GPIOIntr,
  // gpio pins
  input  logic [XLEN-1:0] GPIOPinsIn,
  output logic [XLEN-1:0] GPIOPinsOut,
  output logic [XLEN-1:0] GPIOPinsEn
);

  logic              selTim, selClint, selGpio;
  logic [1:0]        addrD;
  hsizeT             sizeD;
  logic [XLEN-1:0]   wDataLanes;
  logic [XBYTES-1:0] byteEn;
  logic [XLEN-1:0]   timRData, clintRData, gpioRData;
  logic              timReady;

  // decode, data-phase registers and response mux
  busControl busCtl (
    .HCLK, .reset,
    .hAddr, .hTrans, .hWrite, .hSize,
    .timRData, .clintRData, .gpioRData, .timReady,
    .selTim, .selClint, .selGpio,
    .addrD, .sizeD,
    .hRData, .hReady, .hResp);

  // lane replication for byte and halfword stores
  subwordWrite sww (
    .hWData, .sizeD, .addrD,
    .wDataLanes, .byteEn);

  dtim tim (
    .HCLK, .reset,
    .selTim, .hAddr, .hWrite, .hReady,
    .wDataLanes, .byteEn,
    .timRData, .timReady);

  // word-only registers, byteEn not needed
  clint clnt (
    .HCLK, .reset,
    .selClint, .hAddr, .hWrite, .hReady, .wDataLanes,
    .clintRData, .TimerIntM, .SwIntM);

  gpio gpo (
    .HCLK, .reset,
    .selGpio, .hAddr, .hWrite, .hReady, .wDataLanes,
    .GPIOPinsIn,
    .gpioRData, .GPIOPinsOut, .GPIOPinsEn, .GPIOIntr);

endmodule

`default_nettype wire

// ==== gpio.sv ====
// general purpose I/O block
// pin registers, two-flop input synchroniser
// rising-edge pending bits with enable mask and interrupt
`timescale 1ns/1ps
`default_nettype none

module gpio import uncorePkg::*; (
  input  logic            HCLK,
  input  logic            reset,
  input  logic            selGpio,
  input  logic [XLEN-1:0] hAddr,
  input  logic            hWrite,
  input  logic            hReady,
  input  logic [XLEN-1:0] wDataLanes,
  input  logic [XLEN-1:0] GPIOPinsIn,
  output logic [XLEN-1:0] gpioRData,
  output logic [XLEN-1:0] GPIOPinsOut,
  output logic [XLEN-1:0] GPIOPinsEn,
  output logic            GPIOIntr
);

  logic [XLEN-1:0] pinsMeta, pinsSync, inputVal, inputValQ, riseEdge;
  logic [XLEN-1:0] inputEn, outputEn, outputVal, riseIe, riseIp, ipClear;
  logic [XLEN-1:0] rDataQ;
  logic [7:0]      offD;
  logic            wrActiveD, wrEn;

  //////////////////////////////////////////////////////////////////////
  // pin input path
  //////////////////////////////////////////////////////////////////////

  // pins are asynchronous to HCLK
  always_ff @(posedge HCLK) begin
    if (reset) begin
      pinsMeta  <= '0;
      pinsSync  <= '0;
      inputValQ <= '0;
    end else begin
      pinsMeta  <= GPIOPinsIn;
      pinsSync  <= pinsMeta;
      inputValQ <= inputVal;
    end
  end

  assign inputVal = pinsSync & inputEn;
  assign riseEdge = inputVal & ~inputValQ;

  //////////////////////////////////////////////////////////////////////
  // bus side
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK) begin
    if (reset) begin
      wrActiveD <= 1'b0;
    end else if (hReady) begin
      wrActiveD <= selGpio & hWrite;
    end
  end

  always_ff @(posedge HCLK) begin
    if (selGpio & hReady) begin
      offD <= hAddr[7:0];
    end
  end

  assign wrEn    = wrActiveD & hReady;
  assign ipClear = (wrEn && (offD == RISE_IP_OFF)) ? wDataLanes : '0;

  // read sampled at acceptance
  always_ff @(posedge HCLK) begin
    if (selGpio & hReady & ~hWrite) begin
      case (hAddr[7:0])
        INPUT_VAL_OFF:  rDataQ <= inputVal;
        INPUT_EN_OFF:   rDataQ <= inputEn;
        OUTPUT_EN_OFF:  rDataQ <= outputEn;
        OUTPUT_VAL_OFF: rDataQ <= outputVal;
        RISE_IE_OFF:    rDataQ <= riseIe;
        RISE_IP_OFF:    rDataQ <= riseIp;
        default:        rDataQ <= '0;
      endcase
    end
  end

  // a new edge wins over a clear in the same cycle
  always_ff @(posedge HCLK) begin
    if (reset) begin
      inputEn   <= '0;
      outputEn  <= '0;
      outputVal <= '0;
      riseIe    <= '0;
      riseIp    <= '0;
    end else begin
      riseIp <= (riseIp & ~ipClear) | riseEdge;
      if (wrEn) begin
        case (offD)
          INPUT_EN_OFF:   inputEn   <= wDataLanes;
          OUTPUT_EN_OFF:  outputEn  <= wDataLanes;
          OUTPUT_VAL_OFF: outputVal <= wDataLanes;
          RISE_IE_OFF:    riseIe    <= wDataLanes;
          default: ;
        endcase
      end
    end
  end

  assign gpioRData   = rDataQ;
  assign GPIOPinsOut = outputVal;
  assign GPIOPinsEn  = outputEn;
  assign GPIOIntr    = |(riseIp & riseIe);

endmodule

`default_nettype wire

// ==== clint.sv ====
// core-local interruptor
// free-running 64-bit mtime, 64-bit mtimecmp, msip bit
// machine timer and software interrupt outputs
`timescale 1ns/1ps
`default_nettype none

module clint import uncorePkg::*; (
  input  logic            HCLK,
  input  logic            reset,
  input  logic            selClint,
  input  logic [XLEN-1:0] hAddr,
  input  logic            hWrite,
  input  logic            hReady,
  input  logic [XLEN-1:0] wDataLanes,
  output logic [XLEN-1:0] clintRData,
  output logic            TimerIntM,
  output logic            SwIntM
);

  logic [63:0]     mtime, mtimecmp;
  logic            msip;
  logic [15:0]     offD;
  logic [XLEN-1:0] rDataQ;
  logic            wrActiveD, wrEn;

  //////////////////////////////////////////////////////////////////////
  // bus side
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK) begin
    if (reset) begin
      wrActiveD <= 1'b0;
    end else if (hReady) begin
      wrActiveD <= selClint & hWrite;
    end
  end

  // offset held for the data-phase write
  always_ff @(posedge HCLK) begin
    if (selClint & hReady) begin
      offD <= hAddr[15:0];
    end
  end

  assign wrEn = wrActiveD & hReady;

  // read sampled at acceptance
  always_ff @(posedge HCLK) begin
    if (selClint & hReady & ~hWrite) begin
      case (hAddr[15:0])
        MSIP_OFF:             rDataQ <= {{(XLEN-1){1'b0}}, msip};
        MTIMECMP_OFF:         rDataQ <= mtimecmp[31:0];
        MTIMECMP_OFF + 16'd4: rDataQ <= mtimecmp[63:32];
        MTIME_OFF:            rDataQ <= mtime[31:0];
        MTIME_OFF + 16'd4:    rDataQ <= mtime[63:32];
        default:              rDataQ <= '0;
      endcase
    end
  end

  assign clintRData = rDataQ;

  //////////////////////////////////////////////////////////////////////
  // timer registers
  //////////////////////////////////////////////////////////////////////

  // mtime counts every cycle, a written half overrides the count
  always_ff @(posedge HCLK) begin
    if (reset) begin
      mtime    <= '0;
      mtimecmp <= '1;
      msip     <= 1'b0;
    end else begin
      mtime <= mtime + 64'd1;
      if (wrEn) begin
        case (offD)
          MSIP_OFF:             msip            <= wDataLanes[0];
          MTIMECMP_OFF:         mtimecmp[31:0]  <= wDataLanes;
          MTIMECMP_OFF + 16'd4: mtimecmp[63:32] <= wDataLanes;
          MTIME_OFF:            mtime[31:0]     <= wDataLanes;
          MTIME_OFF + 16'd4:    mtime[63:32]    <= wDataLanes;
          default: ;
        endcase
      end
    end
  end

  // timer pending while mtime has reached the compare
  assign TimerIntM = (mtime >= mtimecmp);
  assign SwIntM    = msip;

endmodule

`default_nettype wire

// ==== dtim.sv ====
// tightly integrated data memory
// word-organised array with per-byte writes
// read registered at acceptance, one wait state on read after write
`timescale 1ns/1ps
`default_nettype none

module dtim import uncorePkg::*; (
  input  logic              HCLK,
  input  logic              reset,
  input  logic              selTim,
  input  logic [XLEN-1:0]   hAddr,
  input  logic              hWrite,
  input  logic              hReady,
  input  logic [XLEN-1:0]   wDataLanes,
  input  logic [XBYTES-1:0] byteEn,
  output logic [XLEN-1:0]   timRData,
  output logic              timReady
);

  logic [XLEN-1:0]   mem [TIM_WORDS];
  logic [XLEN-1:0]   rDataQ;
  logic [TIM_AW-1:0] wordA, wordD;
  logic              accept, wrEn, hazard;
  logic              wrActiveD, stallD;

  assign wordA  = hAddr[TIM_AW+1:2];
  assign accept = selTim & hReady;

  // write completes at the data-phase end edge
  assign wrEn = wrActiveD & hReady;

  // read accepted while the same word is being written
  assign hazard = accept & ~hWrite & wrEn & (wordA == wordD);

  always_ff @(posedge HCLK) begin
    if (reset) begin
      wrActiveD <= 1'b0;
      stallD    <= 1'b0;
    end else begin
      stallD <= hazard;
      if (hReady) begin
        wrActiveD <= selTim & hWrite;
      end
    end
  end

  // word address of the data phase
  always_ff @(posedge HCLK) begin
    if (accept) begin
      wordD <= wordA;
    end
  end

  // byte lanes gated by byteEn
  always_ff @(posedge HCLK) begin
    if (wrEn) begin
      for (int i = 0; i < XBYTES; i++) begin
        if (byteEn[i]) begin
          mem[wordD][i*8 +: 8] <= wDataLanes[i*8 +: 8];
        end
      end
    end
  end

  // stall cycle re-reads the merged word
  always_ff @(posedge HCLK) begin
    if (stallD) begin
      rDataQ <= mem[wordD];
    end else if (accept & ~hWrite) begin
      rDataQ <= mem[wordA];
    end
  end

  assign timRData = rDataQ;
  assign timReady = ~stallD;

  // wait state is exactly one cycle
  assert property (@(posedge HCLK) disable iff (reset) !timReady |=> timReady)
    else $error("dtim: timReady low for two cycles");

endmodule

`default_nettype wire

// ==== subwordWrite.sv ====
// sub-word write formatting for the uncore
// byte and halfword lane replication
// byte enables from data-phase size and offset
`timescale 1ns/1ps
`default_nettype none

module subwordWrite import uncorePkg::*; (
  input  logic [XLEN-1:0]   hWData,
  input  hsizeT             sizeD,
  input  logic [1:0]        addrD,
  output logic [XLEN-1:0]   wDataLanes,
  output logic [XBYTES-1:0] byteEn
);

  always_comb begin
    case (sizeD)
      // low byte copied onto every lane
      BYTE: begin
        wDataLanes = {4{hWData[7:0]}};
        byteEn     = 4'b0001 << addrD;
      end
      // low halfword copied onto both halves
      HALF: begin
        wDataLanes = {2{hWData[15:0]}};
        byteEn     = addrD[1] ? 4'b1100 : 4'b0011;
      end
      // full word passes as is
      default: begin
        wDataLanes = hWData;
        byteEn     = 4'b1111;
      end
    endcase
  end

  // master keeps accesses naturally aligned
  always_comb begin
    if (sizeD == HALF) begin
      assert final (addrD[0] == 1'b0)
        else $error("subwordWrite: misaligned halfword at offset %0d", addrD);
    end
    if (sizeD == WORD) begin
      assert final (addrD == 2'b00)
        else $error("subwordWrite: misaligned word at offset %0d", addrD);
    end
  end

endmodule

`default_nettype wire

// ==== busControl.sv ====
// AHB-Lite bus control for the uncore
// address decode into dtim, clint and gpio regions
// data-phase select, size and offset registers
// read data, ready and response multiplexer
`timescale 1ns/1ps
`default_nettype none

module busControl import uncorePkg::*; (
  input  logic            HCLK,
  input  logic            reset,
  input  logic [XLEN-1:0] hAddr,
  input  htransT          hTrans,
  input  logic            hWrite,
  input  hsizeT           hSize,
  input  logic [XLEN-1:0] timRData,
  input  logic [XLEN-1:0] clintRData,
  input  logic [XLEN-1:0] gpioRData,
  input  logic            timReady,
  output logic            selTim,
  output logic            selClint,
  output logic            selGpio,
  output logic [1:0]      addrD,
  output hsizeT           sizeD,
  output logic [XLEN-1:0] hRData,
  output logic            hReady,
  output logic            hResp
);

  logic   transValid;
  logic   timHit, clintHit, gpioHit;
  regionT region, regionD;
  logic   activeD, writeD;

  //////////////////////////////////////////////////////////////////////
  // address phase decode
  //////////////////////////////////////////////////////////////////////

  // only NONSEQ and SEQ carry a transfer
  assign transValid = (hTrans == NONSEQ) || (hTrans == SEQ);

  assign timHit   = (hAddr & ~TIM_RANGE) == TIM_BASE;
  assign clintHit = (hAddr & ~CLINT_RANGE) == CLINT_BASE;
  assign gpioHit  = (hAddr & ~GPIO_RANGE) == GPIO_BASE;

  always_comb begin
    if (timHit) begin
      region = REG_TIM;
    end else if (clintHit) begin
      region = REG_CLINT;
    end else if (gpioHit) begin
      region = REG_GPIO;
    end else begin
      region = REG_NONE;
    end
  end

  // selects qualified by a live transfer
  assign selTim   = transValid & timHit;
  assign selClint = transValid & clintHit;
  assign selGpio  = transValid & gpioHit;

  //////////////////////////////////////////////////////////////////////
  // data phase registers
  //////////////////////////////////////////////////////////////////////

  // capture on accepted address phase and freeze while hReady low
  always_ff @(posedge HCLK) begin
    if (reset) begin
      activeD <= 1'b0;
      regionD <= REG_NONE;
      writeD  <= 1'b0;
      addrD   <= 2'b00;
      sizeD   <= WORD;
    end else if (hReady) begin
      activeD <= transValid;
      if (transValid) begin
        regionD <= region;
        writeD  <= hWrite;
        addrD   <= hAddr[1:0];
        sizeD   <= hSize;
      end
    end
  end

  // read data only for reads and zero for unmapped
  always_comb begin
    hRData = '0;
    if (activeD && !writeD) begin
      case (regionD)
        REG_TIM:   hRData = timRData;
        REG_CLINT: hRData = clintRData;
        REG_GPIO:  hRData = gpioRData;
        default:   hRData = '0;
      endcase
    end
  end

  // dtim is the only region that can stall
  assign hReady = !(activeD && (regionD == REG_TIM)) || timReady;

  // one-cycle error for unmapped data phase
  assign hResp = activeD && (regionD == REG_NONE);

  // regions of the memory map never overlap
  assert property (@(posedge HCLK) disable iff (reset)
    $onehot0({selTim, selClint, selGpio}))
    else $error("busControl: more than one region selected");

endmodule

`default_nettype wire

// ==== uncorePkg.sv ====
// shared definitions for the uncore slice
// bus width, memory map and region ranges
// clint and gpio register offsets
// AHB transfer type, transfer size and region enums
`default_nettype none

package uncorePkg;

  // data bus width and byte lanes
  localparam int XLEN   = 32;
  localparam int XBYTES = XLEN / 8;

  //////////////////////////////////////////////////////////////////////
  // memory map
  //////////////////////////////////////////////////////////////////////

  // region hit when (addr & ~range) == base
  localparam logic [XLEN-1:0] TIM_BASE    = 32'h8000_0000;
  localparam logic [XLEN-1:0] TIM_RANGE   = 32'h0000_03FF;
  localparam logic [XLEN-1:0] CLINT_BASE  = 32'h0200_0000;
  localparam logic [XLEN-1:0] CLINT_RANGE = 32'h0000_FFFF;
  localparam logic [XLEN-1:0] GPIO_BASE   = 32'h1006_0000;
  localparam logic [XLEN-1:0] GPIO_RANGE  = 32'h0000_00FF;

  // dtim depth and word address width
  localparam int TIM_WORDS = 256;
  localparam int TIM_AW    = $clog2(TIM_WORDS);

  // clint offsets, high words sit 4 bytes above
  localparam logic [15:0] MSIP_OFF     = 16'h0000;
  localparam logic [15:0] MTIMECMP_OFF = 16'h4000;
  localparam logic [15:0] MTIME_OFF    = 16'hBFF8;

  // gpio offsets
  localparam logic [7:0] INPUT_VAL_OFF  = 8'h00;
  localparam logic [7:0] INPUT_EN_OFF   = 8'h04;
  localparam logic [7:0] OUTPUT_EN_OFF  = 8'h08;
  localparam logic [7:0] OUTPUT_VAL_OFF = 8'h0C;
  localparam logic [7:0] RISE_IE_OFF    = 8'h18;
  localparam logic [7:0] RISE_IP_OFF    = 8'h1C;

  // AHB encodings
  typedef enum logic [1:0] {IDLE = 2'b00, BUSY = 2'b01, NONSEQ = 2'b10, SEQ = 2'b11} htransT;
  typedef enum logic [2:0] {BYTE = 3'b000, HALF = 3'b001, WORD = 3'b010} hsizeT;

  // decoded target of a transfer
  typedef enum logic [1:0] {REG_NONE, REG_TIM, REG_CLINT, REG_GPIO} regionT;

endpackage

`default_nettype wire
